//--- Makefile
BUILD_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module sweepAcqTb -f sweepAcqTop.f \
		-Mdir $(BUILD_DIR) -o sweepAcqSim

run: compile
	./$(BUILD_DIR)/sweepAcqSim

clean:
	rm -rf $(BUILD_DIR)

//--- design/acqDataFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "sweepAcq_defs.svh"

module acqDataFifo #(
    parameter int Depth = `FIFO_DEPTH
) (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  sweepAcqPkg::acqWord_t Wr,
    input  logic                  RdEn,
    output logic [15:0]           RdData,
    output logic                  Empty,
    output logic                  Full
);

    localparam int AddrWidth = $clog2(Depth);

    logic [15:0]        mem [Depth];
    // Extra pointer bit tells full from empty
    logic [AddrWidth:0] wrPtr;
    logic [AddrWidth:0] rdPtr;
    logic               doWrite;
    logic               doRead;

    assign doWrite = Wr.Valid && !Full;
    assign doRead  = RdEn && !Empty;
    assign Empty   = (wrPtr == rdPtr);
    assign Full    = (wrPtr[AddrWidth] != rdPtr[AddrWidth]) &&
                     (wrPtr[AddrWidth-1:0] == rdPtr[AddrWidth-1:0]);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead)  rdPtr <= rdPtr + 1'b1;
        end
    end

    // Storage and registered read port
    always_ff @(posedge Clk) begin
        if (doWrite) mem[wrPtr[AddrWidth-1:0]] <= Wr.Data;
        if (doRead)  RdData <= mem[rdPtr[AddrWidth-1:0]];
    end

endmodule

`default_nettype wire

//--- design/scParamLoader.sv
`timescale 1ns/1ps
`default_nettype none

module scParamLoader (
    input  logic       Clk,
    input  logic       reset_n,
    input  logic       LoadSc,
    input  logic [9:0] ScCode,
    output logic       ScData,
    output logic       ScShift,
    output logic       ConfigDone
);

    logic [9:0] shiftReg;
    logic [3:0] bitsLeft;
    logic       startLoad;

    // A load request during a shift is dropped
    assign startLoad = LoadSc && !ScShift;

    // MSB of the shift register drives the chain
    assign ScData = shiftReg[9];

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ScShift    <= 1'b0;
            ConfigDone <= 1'b0;
            bitsLeft   <= 4'd0;
        end else begin
            ConfigDone <= 1'b0;
            if (startLoad) begin
                ScShift  <= 1'b1;
                bitsLeft <= 4'd9;
            end else if (ScShift) begin
                if (bitsLeft == 4'd0) begin
                    ScShift    <= 1'b0;
                    ConfigDone <= 1'b1;
                end else begin
                    bitsLeft <= bitsLeft - 4'd1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (startLoad) begin
            shiftReg <= ScCode;
        end else if (ScShift) begin
            shiftReg <= {shiftReg[8:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- design/sweepAcqControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sweepAcq_defs.svh"

module sweepAcqControl (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   SweepStart,
    input  logic                   DataTransmitDone,
    input  sweepAcqPkg::sweepCfg_t Cfg,
    input  sweepAcqPkg::acqWord_t  FrontEnd,
    input  logic                   ConfigDone,
    input  logic [15:0]            RdData,
    output logic                   AcqStart,
    output logic                   OneDacDone,
    output logic                   AcqDone,
    output logic                   LoadSc,
    output logic [9:0]             ScCode,
    output logic                   RdEn,
    output sweepAcqPkg::acqWord_t  SweepOut
);
    import sweepAcqPkg::*;

    localparam logic [3:0]  lastWordIdx = 4'(`PACKET_WORDS - 1);
    localparam logic [15:0] settleCycles = 16'(`SC_SETTLE_DELAY);

    sweepState_e state;
    sweepCfg_t   cfgReg;
    logic [9:0]  curDac;
    logic [15:0] settleCnt;
    logic [15:0] pktCount;
    logic [3:0]  wordCnt;
    logic [3:0]  fillCnt;
    logic [2:0]  pendingPkts;
    logic        packetDone;
    logic        packetReady;
    logic        packetTaken;

    // The ASIC chain expects the DAC code LSB first
    function automatic logic [9:0] reverseBits(input logic [9:0] code);
        logic [9:0] rev;
        for (int i = 0; i < 10; i++) begin
            rev[i] = code[9 - i];
        end
        return rev;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Front-end packet tracking
    //////////////////////////////////////////////////////////////////////

    assign packetDone  = FrontEnd.Valid && (fillCnt == lastWordIdx);
    assign packetReady = (pendingPkts != 3'd0);
    assign packetTaken = (state == WaitPacket) && packetReady;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            fillCnt     <= 4'd0;
            pendingPkts <= 3'd0;
        end else begin
            if (FrontEnd.Valid) begin
                fillCnt <= packetDone ? 4'd0 : fillCnt + 4'd1;
            end
            // Complete packets sitting in the FIFO, not yet read out
            case ({packetDone, packetTaken})
                2'b10:   pendingPkts <= pendingPkts + 3'd1;
                2'b01:   pendingPkts <= pendingPkts - 3'd1;
                default: pendingPkts <= pendingPkts;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= Idle;
            curDac     <= 10'd0;
            settleCnt  <= 16'd0;
            pktCount   <= 16'd0;
            wordCnt    <= 4'd0;
            AcqStart   <= 1'b0;
            OneDacDone <= 1'b0;
            AcqDone    <= 1'b0;
            LoadSc     <= 1'b0;
            RdEn       <= 1'b0;
            SweepOut   <= '0;
        end else begin
            // Strobes are high for one cycle only
            SweepOut.Valid <= 1'b0;
            OneDacDone     <= 1'b0;
            LoadSc         <= 1'b0;
            RdEn           <= 1'b0;

            case (state)
                Idle: begin
                    if (SweepStart) begin
                        SweepOut.Data <= `HEADER_WORD;
                        curDac        <= Cfg.StartDac;
                        pktCount      <= 16'd0;
                        wordCnt       <= 4'd0;
                        state         <= HeaderOut;
                    end
                end
                HeaderOut: begin
                    SweepOut.Valid <= 1'b1;
                    state          <= StepOut;
                end
                StepOut: begin
                    SweepOut.Data <= {`DAC_MARK, 2'b00, curDac};
                    state         <= sweepAcqPkg::LoadSc;
                end
                // Port LoadSc hides the state of the same name here
                sweepAcqPkg::LoadSc: begin
                    SweepOut.Valid <= 1'b1;
                    LoadSc         <= 1'b1;
                    state          <= WaitLoad;
                end
                WaitLoad: begin
                    if (settleCnt == 16'd0) begin
                        if (ConfigDone) begin
                            settleCnt <= 16'd1;
                        end
                    end else if (settleCnt == settleCycles) begin
                        settleCnt <= 16'd0;
                        state     <= StartAcq;
                    end else begin
                        settleCnt <= settleCnt + 16'd1;
                    end
                end
                StartAcq: begin
                    AcqStart <= 1'b1;
                    state    <= WaitPacket;
                end
                WaitPacket: begin
                    if (packetReady) begin
                        RdEn  <= 1'b1;
                        state <= ReadWord;
                    end
                end
                ReadWord: begin
                    state <= WaitWord;
                end
                WaitWord: begin
                    SweepOut.Data <= RdData;
                    state         <= OutWord;
                end
                OutWord: begin
                    SweepOut.Valid <= 1'b1;
                    if (wordCnt != lastWordIdx) begin
                        RdEn    <= 1'b1;
                        wordCnt <= wordCnt + 4'd1;
                        state   <= ReadWord;
                    end else begin
                        wordCnt <= 4'd0;
                        state   <= CheckStep;
                    end
                end
                CheckStep: begin
                    if (pktCount + 16'd1 < cfgReg.MaxPackageNumber) begin
                        pktCount <= pktCount + 16'd1;
                        state    <= WaitPacket;
                    end else begin
                        pktCount   <= 16'd0;
                        AcqStart   <= 1'b0;
                        OneDacDone <= 1'b1;
                        state      <= CheckAll;
                    end
                end
                CheckAll: begin
                    if (curDac != cfgReg.EndDac) begin
                        curDac <= curDac + 10'd1;
                        state  <= StepOut;
                    end else begin
                        SweepOut.Data <= `TAIL_WORD;
                        state         <= TailOut;
                    end
                end
                TailOut: begin
                    SweepOut.Valid <= 1'b1;
                    state          <= WaitDone;
                end
                WaitDone: begin
                    AcqDone <= 1'b1;
                    state   <= AllDone;
                end
                AllDone: begin
                    // Hold done until the link has shipped the frame
                    if (DataTransmitDone) begin
                        AcqDone <= 1'b0;
                        state   <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Sweep parameters and loader code
    always_ff @(posedge Clk) begin
        if (state == Idle && SweepStart) begin
            cfgReg <= Cfg;
        end
        if (state == StepOut) begin
            ScCode <= reverseBits(curDac);
        end
    end

endmodule

`default_nettype wire

//--- design/sweepAcqPkg.sv
`default_nettype none

package sweepAcqPkg;

    // One word on the front-end or output stream
    typedef struct packed {
        logic [15:0] Data;
        logic        Valid;
    } acqWord_t;

    // Sweep parameters, sampled at sweep start
    typedef struct packed {
        logic [9:0]  StartDac;
        logic [9:0]  EndDac;
        logic [15:0] MaxPackageNumber;
    } sweepCfg_t;

    typedef enum logic [3:0] {
        Idle,
        HeaderOut,
        StepOut,
        LoadSc,
        WaitLoad,
        StartAcq,
        WaitPacket,
        ReadWord,
        WaitWord,
        OutWord,
        CheckStep,
        CheckAll,
        TailOut,
        WaitDone,
        AllDone
    } sweepState_e;

endpackage

`default_nettype wire

//--- design/sweepAcqTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "sweepAcq_defs.svh"

module sweepAcqTop (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   SweepStart,
    input  logic                   DataTransmitDone,
    input  sweepAcqPkg::sweepCfg_t Cfg,
    input  sweepAcqPkg::acqWord_t  FrontEnd,
    output sweepAcqPkg::acqWord_t  SweepOut,
    output logic                   AcqStart,
    output logic                   OneDacDone,
    output logic                   AcqDone,
    output logic                   ScData,
    output logic                   ScShift,
    output logic                   FifoFull
);

    logic        loadSc;
    logic [9:0]  scCode;
    logic        configDone;
    logic        rdEn;
    logic [15:0] rdData;

    sweepAcqControl control0 (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .DataTransmitDone (DataTransmitDone),
        .Cfg              (Cfg),
        .FrontEnd         (FrontEnd),
        .ConfigDone       (configDone),
        .RdData           (rdData),
        .AcqStart         (AcqStart),
        .OneDacDone       (OneDacDone),
        .AcqDone          (AcqDone),
        .LoadSc           (loadSc),
        .ScCode           (scCode),
        .RdEn             (rdEn),
        .SweepOut         (SweepOut)
    );

    scParamLoader loader0 (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .LoadSc     (loadSc),
        .ScCode     (scCode),
        .ScData     (ScData),
        .ScShift    (ScShift),
        .ConfigDone (configDone)
    );

    // Empty is only used inside the FIFO
    acqDataFifo #(
        .Depth (`FIFO_DEPTH)
    ) fifo0 (
        .Clk     (Clk),
        .reset_n (reset_n),
        .Wr      (FrontEnd),
        .RdEn    (rdEn),
        .RdData  (rdData),
        .Empty   (),
        .Full    (FifoFull)
    );

endmodule

`default_nettype wire

//--- design/sweepAcq_defs.svh
`ifndef SWEEPACQ_DEFS_SVH
`define SWEEPACQ_DEFS_SVH

// Data words in one front-end hit packet
`define PACKET_WORDS 10

// Cycles between config-done and acquisition start
// Short value for simulation, the board uses far more
`define SC_SETTLE_DELAY 40

// Entries in the acquisition data FIFO, power of two
`define FIFO_DEPTH 32

//////////////////////////////////////////////////////////////////////
// Frame marker words
//////////////////////////////////////////////////////////////////////

// ASCII "SA" opens a sweep frame
`define HEADER_WORD 16'h5341
`define TAIL_WORD 16'hFF45
// Top nibble of each step marker
`define DAC_MARK 4'hD

`endif

//--- sweepAcqTop.f
+incdir+design
design/sweepAcqPkg.sv
design/sweepAcqControl.sv
design/scParamLoader.sv
design/acqDataFifo.sv
design/sweepAcqTop.sv
test/clockGen.sv
test/sweepAcq_sva.sv
test/sweepAcqTb.sv

//--- test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod  = 20,
    parameter int ResetCycles = 5
) (
    output logic Clk,
    output logic reset_n
);

    initial begin
        Clk = 1'b0;
        forever #(HalfPeriod) Clk = ~Clk;
    end

    // Reset released on a rising edge after the hold time
    initial begin
        reset_n = 1'b0;
        repeat (ResetCycles) @(posedge Clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- test/sweepAcqTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sweepAcq_defs.svh"

module sweepAcqTb;
    import sweepAcqPkg::*;

    localparam int WaitLimit  = 2000;
    localparam int FrameLimit = 20000;
    localparam int SweepRuns  = 3;

    logic      Clk;
    logic      reset_n;
    logic      SweepStart;
    logic      DataTransmitDone;
    sweepCfg_t Cfg;
    acqWord_t  FrontEnd;
    acqWord_t  SweepOut;
    logic      AcqStart;
    logic      OneDacDone;
    logic      AcqDone;
    logic      ScData;
    logic      ScShift;
    logic      FifoFull;

    // Reference model queues, rebuilt for each sweep
    acqWord_t    expQ[$];
    logic [9:0]  codeQ[$];
    logic [15:0] sendQ[$];
    int          outCount;

    clockGen clk0 (
        .Clk     (Clk),
        .reset_n (reset_n)
    );

    sweepAcqTop dut0 (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .DataTransmitDone (DataTransmitDone),
        .Cfg              (Cfg),
        .FrontEnd         (FrontEnd),
        .SweepOut         (SweepOut),
        .AcqStart         (AcqStart),
        .OneDacDone       (OneDacDone),
        .AcqDone          (AcqDone),
        .ScData           (ScData),
        .ScShift          (ScShift),
        .FifoFull         (FifoFull)
    );

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stopRun();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic reportFail(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    task automatic checkWord(input string name, input acqWord_t got, input acqWord_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkCode(input string name, input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            stopRun();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Waits, each bounded
    //////////////////////////////////////////////////////////////////////

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1) begin
            @(negedge Clk);
            cycles++;
            if (cycles > WaitLimit) reportFail("reset was never released");
        end
    endtask

    task automatic waitAcqStart(input logic level);
        int cycles;
        cycles = 0;
        while (AcqStart !== level) begin
            @(negedge Clk);
            cycles++;
            if (cycles > WaitLimit) reportFail("AcqStart did not reach the expected level");
        end
    endtask

    task automatic waitAcqDone(input logic level);
        int cycles;
        cycles = 0;
        while (AcqDone !== level) begin
            @(negedge Clk);
            cycles++;
            if (cycles > WaitLimit) reportFail("AcqDone did not reach the expected level");
        end
    endtask

    // outCount moves on falling edges, so poll it on rising ones
    task automatic waitOutCount(input int target);
        int cycles;
        cycles = 0;
        while (outCount < target) begin
            @(posedge Clk);
            cycles++;
            if (cycles > WaitLimit) reportFail("packet was not read out of the FIFO in time");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Front end and output monitor
    //////////////////////////////////////////////////////////////////////

    task automatic driveFrontEnd(input int steps, input int pkts);
        int gap;
        for (int s = 0; s < steps; s++) begin
            waitAcqStart(1'b1);
            for (int p = 0; p < pkts; p++) begin
                for (int w = 0; w < `PACKET_WORDS; w++) begin
                    gap = $urandom % 4;
                    repeat (gap) begin
                        @(posedge Clk);
                        FrontEnd <= '0;
                    end
                    @(posedge Clk);
                    FrontEnd <= '{Data: sendQ.pop_front(), Valid: 1'b1};
                end
                @(posedge Clk);
                FrontEnd <= '0;
                // Header, earlier steps, this marker, packets so far
                waitOutCount(2 + s * (1 + pkts * `PACKET_WORDS) + (p + 1) * `PACKET_WORDS);
            end
            waitAcqStart(1'b0);
        end
    endtask

    task automatic monitorSweep(input int steps);
        int         cycles;
        int         bitCount;
        int         dacDones;
        logic [9:0] serCode;
        acqWord_t   expWord;
        cycles   = 0;
        bitCount = 0;
        dacDones = 0;
        serCode  = '0;
        while (AcqDone !== 1'b1) begin
            @(negedge Clk);
            cycles++;
            if (cycles > FrameLimit) reportFail("sweep frame did not finish in time");
            checkLevel("FifoFull", FifoFull, 1'b0);
            if (SweepOut.Valid) begin
                if (expQ.size() == 0) reportFail("extra word appeared on SweepOut");
                expWord = expQ.pop_front();
                checkWord("SweepOut", SweepOut, expWord);
                outCount++;
            end
            // Serial chain gets the DAC value LSB first
            if (ScShift) begin
                checkLevel("AcqStart", AcqStart, 1'b0);
                serCode = {ScData, serCode[9:1]};
                bitCount++;
                if (bitCount == 10) begin
                    if (codeQ.size() == 0) reportFail("more slow-control loads than steps");
                    checkCode("ScData", serCode, codeQ.pop_front());
                    bitCount = 0;
                end
            end
            if (OneDacDone) begin
                checkLevel("AcqStart", AcqStart, 1'b0);
                dacDones++;
            end
        end
        if (expQ.size() != 0) reportFail("AcqDone rose before the whole frame was sent");
        if (codeQ.size() != 0 || bitCount != 0) reportFail("slow-control load missing");
        if (dacDones != steps) reportFail("wrong number of OneDacDone pulses");
    endtask

    task automatic runSweep();
        sweepCfg_t   cfg;
        int          span;
        int          pkts;
        int          holdCycles;
        logic [9:0]  dac;
        logic [15:0] data;
        span = $urandom % 4;
        pkts = 1 + $urandom % 3;
        cfg.StartDac         = 10'($urandom % 1021);
        cfg.EndDac           = cfg.StartDac + 10'(span);
        cfg.MaxPackageNumber = 16'(pkts);

        // Expected frame and serial codes
        expQ.delete();
        codeQ.delete();
        sendQ.delete();
        outCount = 0;
        expQ.push_back('{Data: `HEADER_WORD, Valid: 1'b1});
        for (int s = 0; s <= span; s++) begin
            dac = cfg.StartDac + 10'(s);
            codeQ.push_back(dac);
            expQ.push_back('{Data: {`DAC_MARK, 2'b00, dac}, Valid: 1'b1});
            for (int i = 0; i < pkts * `PACKET_WORDS; i++) begin
                data = 16'($urandom);
                sendQ.push_back(data);
                expQ.push_back('{Data: data, Valid: 1'b1});
            end
        end
        expQ.push_back('{Data: `TAIL_WORD, Valid: 1'b1});

        @(posedge Clk);
        Cfg        <= cfg;
        SweepStart <= 1'b1;
        fork
            begin
                @(posedge Clk);
                SweepStart <= 1'b0;
                driveFrontEnd(span + 1, pkts);
            end
            monitorSweep(span + 1);
        join

        // Done must hold until the link acknowledges
        holdCycles = 2 + $urandom % 6;
        repeat (holdCycles) begin
            @(negedge Clk);
            checkLevel("AcqDone", AcqDone, 1'b1);
        end
        @(posedge Clk);
        DataTransmitDone <= 1'b1;
        waitAcqDone(1'b0);
        @(posedge Clk);
        DataTransmitDone <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(57075));
        outCount         = 0;
        SweepStart       = 1'b0;
        DataTransmitDone = 1'b0;
        Cfg              = '0;
        FrontEnd         = '0;

        waitReset();
        @(negedge Clk);
        checkLevel("SweepOut.Valid", SweepOut.Valid, 1'b0);
        checkLevel("LoadSc", dut0.control0.LoadSc, 1'b0);
        checkLevel("RdEn", dut0.control0.RdEn, 1'b0);
        checkLevel("AcqStart", AcqStart, 1'b0);
        checkLevel("OneDacDone", OneDacDone, 1'b0);
        checkLevel("AcqDone", AcqDone, 1'b0);
        checkLevel("ScShift", ScShift, 1'b0);
        checkLevel("ConfigDone", dut0.configDone, 1'b0);

        for (int run = 0; run < SweepRuns; run++) begin
            runSweep();
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sweepAcq_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_sva (
    input logic                     Clk,
    input logic                     reset_n,
    input sweepAcqPkg::sweepState_e state,
    input sweepAcqPkg::acqWord_t    SweepOut,
    input logic                     OneDacDone,
    input logic                     LoadSc,
    input logic                     ConfigDone,
    input logic                     RdEn
);
    import sweepAcqPkg::*;

    // High from a load request until the loader reports done
    logic loadBusy;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            loadBusy <= 1'b0;
        end else if (LoadSc) begin
            loadBusy <= 1'b1;
        end else if (ConfigDone) begin
            loadBusy <= 1'b0;
        end
    end

    validPulse: assert property (@(posedge Clk) disable iff (!reset_n)
        SweepOut.Valid |=> !SweepOut.Valid)
        else $error("SweepOut.Valid high for more than one cycle");

    dacDonePulse: assert property (@(posedge Clk) disable iff (!reset_n)
        OneDacDone |=> !OneDacDone)
        else $error("OneDacDone high for more than one cycle");

    loadOnce: assert property (@(posedge Clk) disable iff (!reset_n)
        LoadSc |-> !loadBusy)
        else $error("LoadSc raised again before ConfigDone");

    noReadInIdle: assert property (@(posedge Clk) disable iff (!reset_n)
        (state == Idle) |-> !RdEn)
        else $error("RdEn high while the controller is idle");

endmodule

bind sweepAcqControl sweep_sva sva0 (
    .Clk        (Clk),
    .reset_n    (reset_n),
    .state      (state),
    .SweepOut   (SweepOut),
    .OneDacDone (OneDacDone),
    .LoadSc     (LoadSc),
    .ConfigDone (ConfigDone),
    .RdEn       (RdEn)
);

`default_nettype wire
